/* key_conditioner.sv */
module key_conditioner (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [2:0] key,
  tick_if.sink       ticks,
  output logic       up_evt,
  output logic       down_evt,
  output logic       rst_evt
);

  logic [2:0] key_meta;
  logic [2:0] key_sync;   // High while pressed
  logic       up_held;
  logic       down_held;

  // ==============================
  // Key synchronizers
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;   // Keys are active low
      key_sync <= key_meta;
    end
  end

  // Both keys held cancel each other
  assign up_held   = key_sync[0] & ~key_sync[1];
  assign down_held = key_sync[1] & ~key_sync[0];

  // ==============================
  // Timed repeat
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_evt   <= 1'b0;
      down_evt <= 1'b0;
    end
    else
    begin
      up_evt   <= ticks.tick_repeat & up_held;
      down_evt <= ticks.tick_repeat & down_held;
    end
  end

  // Reset key stays a level
  assign rst_evt = key_sync[2];

endmodule

/* led_chaser.sv */
module led_chaser (
  input  logic       CLK_50M,
  input  logic       arst_n,
  tick_if.sink       ticks,
  output logic [7:0] ledr
);

  logic dir_down;   // 0 moves toward bit 7

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ledr     <= 8'h01;
      dir_down <= 1'b0;
    end
    else if (ticks.tick_led)
    begin
      if (!dir_down)
      begin
        ledr <= ledr << 1;
        if (ledr[6])
        begin
          dir_down <= 1'b1;   // Turn at the top
        end
      end
      else
      begin
        ledr <= ledr >> 1;
        if (ledr[1])
        begin
          dir_down <= 1'b0;   // Turn at the bottom
        end
      end
    end
  end

endmodule

/* organ_checker.sv */
module organ_checker #(
  parameter logic [31:0] clk_hz = 32'd50_000_000
) (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [7:0] sw,
  input  logic       tone_out,
  input  logic [7:0] audio_sample,
  input  logic [7:0] ledr
);
  timeunit 1ns;
  timeprecision 100ps;
  import organ_pkg::*;

  int unsigned fail_count;   // Read by the testbench
  logic [7:0]  sw_d;
  note_e       note_exp;     // Note as the switches select it
  note_e       note_d;
  logic        tone_d;
  logic [31:0] run_len;      // Cycles since tone or note last changed
  logic [31:0] hp_exp;

  // Lowest set switch, silent when none
  function automatic note_e lowest_note(logic [7:0] s);
    for (int i = 0; i < 8; i++)
    begin
      if (s[i])
      begin
        return note_e'(i);
      end
    end
    return silent_n;
  endfunction

  initial fail_count = 0;

  assign hp_exp = half_period(clk_hz, note_exp);

  // ==============================
  // Reference of the note pipeline
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sw_d     <= '0;
      note_exp <= silent_n;
      note_d   <= silent_n;
      tone_d   <= 1'b0;
      run_len  <= '0;
    end
    else
    begin
      sw_d     <= sw;                  // Switch register stage
      note_exp <= lowest_note(sw_d);
      note_d   <= note_exp;
      tone_d   <= tone_out;
      if (tone_out != tone_d || note_exp != note_d)
      begin
        run_len <= 32'd1;
      end
      else
      begin
        run_len <= run_len + 32'd1;
      end
    end
  end

  // ==============================
  // Assertions
  // ==============================
  a_sample: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    audio_sample == (tone_out ? 8'h7f : 8'h80))
  else
  begin
    fail_count++;
    $error("ERR audio_sample exp %h got %h", tone_out ? 8'h7f : 8'h80, audio_sample);
  end

  a_onehot: assert property (@(posedge CLK_50M) disable iff (!arst_n) $onehot(ledr))
  else
  begin
    fail_count++;
    $error("ERR ledr is not one-hot, got %h", ledr);
  end

  // A toggle within one note ends a run of exactly half_period cycles
  a_period: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (tone_out != tone_d && note_exp == note_d && note_exp != silent_n) |-> run_len == hp_exp)
  else
  begin
    fail_count++;
    $error("ERR tone_out run length exp %h got %h", hp_exp, run_len);
  end

  a_silent: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    note_exp == silent_n |-> !tone_out)
  else
  begin
    fail_count++;
    $error("ERR tone_out exp %h got %h with no switch set", 1'b0, tone_out);
  end

endmodule

/* organ_pkg.sv */
package organ_pkg;

  // ==============================
  // Notes of the C scale
  // ==============================
  typedef enum logic [3:0] {
    do_n,
    re_n,
    mi_n,
    fa_n,
    so_n,
    la_n,
    si_n,
    do2_n,
    silent_n
  } note_e;

  function automatic logic [31:0] note_hz(note_e n);
    case (n)
      do_n:    return 32'd523;
      re_n:    return 32'd587;
      mi_n:    return 32'd659;
      fa_n:    return 32'd698;
      so_n:    return 32'd784;
      la_n:    return 32'd880;
      si_n:    return 32'd988;
      do2_n:   return 32'd1047;
      default: return 32'd0;     // Silent
    endcase
  endfunction

  // Clock cycles per half tone period
  function automatic logic [31:0] half_period(logic [31:0] clk_rate, note_e n);
    logic [31:0] hz;
    hz = note_hz(n);
    if (hz == 32'd0)
    begin
      return 32'd0;
    end
    return clk_rate / (hz << 1);
  endfunction

  // ==============================
  // Seven-segment, active low, gfedcba
  // ==============================
  function automatic logic [6:0] seg_encode(logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;   // F
    endcase
  endfunction

  // Scope sampling divider, 2 kHz at 50 MHz
  localparam logic [15:0] scope_count_default = 16'd12499;
  localparam logic [15:0] scope_step          = 16'd100;

endpackage

/* organ_timebase.sv */
module organ_timebase #(
  parameter logic [31:0] clk_hz    = 32'd50_000_000,
  parameter logic [31:0] repeat_hz = 32'd10
) (
  input  logic CLK_50M,
  input  logic arst_n,
  tick_if.src  ticks
);

  // Ratios: kHz, repeat (in kHz ticks), LED, display
  localparam logic [3:0][31:0] div_tab = {
    clk_hz / 32'd2,
    clk_hz,
    32'd1000 / repeat_hz,
    clk_hz / 32'd1000
  };

  logic [3:0] tick_v;
  logic [3:0] step;

  assign step = {2'b11, tick_v[0], 1'b1};   // Repeat counter steps on kHz ticks

  // ==============================
  // One counter per tick
  // ==============================
  for (genvar i = 0; i < 4; i++)
  begin : g_div
    logic [31:0] cnt;
    logic        tick;

    always_ff @(posedge CLK_50M or negedge arst_n)
    begin
      if (!arst_n)
      begin
        cnt  <= '0;
        tick <= 1'b0;
      end
      else if (step[i])
      begin
        if (cnt == div_tab[i] - 32'd1)
        begin
          cnt  <= '0;
          tick <= 1'b1;
        end
        else
        begin
          cnt  <= cnt + 32'd1;
          tick <= 1'b0;
        end
      end
      else
      begin
        tick <= 1'b0;
      end
    end

    assign tick_v[i] = tick;
  end

  assign ticks.tick_khz     = tick_v[0];
  assign ticks.tick_repeat  = tick_v[1];
  assign ticks.tick_led     = tick_v[2];
  assign ticks.tick_display = tick_v[3];

endmodule

/* organ_top.sv */
module organ_top #(
  parameter logic [31:0] clk_hz    = 32'd50_000_000,
  parameter logic [31:0] repeat_hz = 32'd10
) (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic [7:0]  sw,
  input  logic [2:0]  key,
  output logic        tone_out,
  output logic [7:0]  audio_sample,
  output logic [7:0]  ledr,
  output logic [15:0] scope_count,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  tick_if u_ticks ();

  logic up_evt;
  logic down_evt;
  logic rst_evt;

  // ==============================
  // Time base and tone
  // ==============================
  organ_timebase #(
    .clk_hz    (clk_hz),
    .repeat_hz (repeat_hz)
  ) u_timebase (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .ticks   (u_ticks)
  );

  tone_generator #(
    .clk_hz (clk_hz)
  ) u_tone (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sw           (sw),
    .tone_out     (tone_out),
    .audio_sample (audio_sample)
  );

  led_chaser u_leds (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .ticks   (u_ticks),
    .ledr    (ledr)
  );

  // ==============================
  // Scope rate keys and display
  // ==============================
  key_conditioner u_keys (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .key      (key),
    .ticks    (u_ticks),
    .up_evt   (up_evt),
    .down_evt (down_evt),
    .rst_evt  (rst_evt)
  );

  scope_rate_ctrl u_rate (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .up_evt   (up_evt),
    .down_evt (down_evt),
    .rst_evt  (rst_evt),
    .count    (scope_count)
  );

  seg_display u_display (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .count   (scope_count),
    .ticks   (u_ticks),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the organ testbench with Verilator and run it

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_organ -o sim_organ
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_organ +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
  exit 1
fi
exit 0

/* scope_rate_ctrl.sv */
module scope_rate_ctrl (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic        up_evt,
  input  logic        down_evt,
  input  logic        rst_evt,
  output logic [15:0] count
);
  import organ_pkg::*;

  logic signed [15:0] offset;

  // Offset from the default, wraps at 16 bits
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      offset <= '0;
    end
    else if (rst_evt)
    begin
      offset <= '0;                            // Reset key first
    end
    else if (up_evt)
    begin
      offset <= offset + signed'(scope_step);
    end
    else if (down_evt)
    begin
      offset <= offset - signed'(scope_step);
    end
  end

  // Registered count, modulo 2^16
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= scope_count_default;
    end
    else
    begin
      count <= scope_count_default + unsigned'(offset);
    end
  end

endmodule

/* seg_display.sv */
module seg_display (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic [15:0] count,
  tick_if.sink        ticks,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);
  import organ_pkg::*;

  logic [23:0]      shown;   // Upper byte always zero
  logic [5:0][6:0]  seg_q;

  // Sample the count at the display rate
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shown <= '0;
    end
    else if (ticks.tick_display)
    begin
      shown <= {8'h00, count};
    end
  end

  // ==============================
  // Digit decode
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 6; i++)
      begin
        seg_q[i] <= seg_encode(4'h0);
      end
    end
    else
    begin
      for (int i = 0; i < 6; i++)
      begin
        seg_q[i] <= seg_encode(shown[i*4 +: 4]);
      end
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

/* tb_organ.sv */
module tb_organ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] clk_hz     = 32'd100_000;
  localparam int          repeat_cyc = 10_000;   // Clock cycles per key repeat
  localparam longint      run_cycles = 17 * 100_000 + 14 * repeat_cyc + 60_000 + 10_000;
  localparam longint      limit_ns   = run_cycles * 20;

  localparam logic [15:0] count_default = 16'd12499;
  localparam logic [15:0] count_step    = 16'd100;

  // Active low gfedcba patterns for 0 to F
  localparam logic [6:0] seg_ref [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic        CLK_50M;
  logic        arst_n;
  logic [7:0]  sw;
  logic [2:0]  key;
  logic        tone_out;
  logic [7:0]  audio_sample;
  logic [7:0]  ledr;
  logic [15:0] scope_count;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;
  int          errors;
  logic [31:0] rnd;

  organ_top #(
    .clk_hz (clk_hz)
  ) u_dut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sw           (sw),
    .key          (key),
    .tone_out     (tone_out),
    .audio_sample (audio_sample),
    .ledr         (ledr),
    .scope_count  (scope_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  bind organ_top organ_checker #(.clk_hz(clk_hz)) u_chk (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sw           (sw),
    .tone_out     (tone_out),
    .audio_sample (audio_sample),
    .ledr         (ledr)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Half period in cycles of the lowest set switch
  function automatic int note_cycles(logic [7:0] s);
    int hz [8];
    hz = '{523, 587, 659, 698, 784, 880, 988, 1047};
    for (int i = 0; i < 8; i++)
    begin
      if (s[i])
      begin
        return int'(clk_hz / (32'd2 * hz[i]));
      end
    end
    return 0;
  endfunction

  function automatic int total_fails();
    return errors + int'(u_dut.u_chk.fail_count);
  endfunction

  function automatic logic [15:0] watched(int which);
    case (which)
      0:       return {15'd0, tone_out};
      1:       return {8'd0, ledr};
      default: return scope_count;
    endcase
  endfunction

  // Waits for a change on tone_out (0), ledr (1) or scope_count (2)
  task automatic wait_change(input string name, input int which, input int limit,
                             output int cycles);
    logic [15:0] prev;
    prev = watched(which);
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    while (watched(which) == prev && cycles <= limit);
    if (cycles > limit)
    begin
      $display("No change on %s within %0d cycles", name, limit);
      errors++;
    end
  endtask

  task automatic check_digit(input string name, input logic [6:0] got, input logic [3:0] nib);
    assert (got == seg_ref[nib])
    else
    begin
      $display("ERR %s exp %h got %h", name, seg_ref[nib], got);
      errors++;
    end
  endtask

  task automatic check_count(input logic [15:0] exp);
    assert (scope_count == exp)
    else
    begin
      $display("ERR scope_count exp %h got %h", exp, scope_count);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    if (total_fails() == start)
    begin
      $display("%s: pass", name);
    end
    else
    begin
      $display("%s: fail, %0d errors", name, total_fails() - start);
    end
  endtask

  task automatic press_for(input int k, input int changes);
    int cycles;
    @(posedge CLK_50M);
    #2 key[k] = 1'b0;
    for (int i = 0; i < changes; i++)
    begin
      wait_change("scope_count", 2, repeat_cyc + 10, cycles);
    end
    @(posedge CLK_50M);
    #2 key[k] = 1'b1;
    repeat (10) @(negedge CLK_50M);   // Drain of the key pipeline
  endtask

  // ==============================
  // Watchdog
  // ==============================
  initial
  begin
    #(limit_ns);
    $display("Timeout, the tests did not finish within %0d ns", limit_ns);
    $display("RESULT: FAIL");
    $finish;
  end

  // ==============================
  // Tests
  // ==============================
  initial
  begin
    int          start;
    int          cycles;
    int          hp;
    int          highs;
    logic        seen_top;
    logic        back_home;
    logic [7:0]  pattern;
    logic [15:0] exp_count;
    errors = 0;
    rnd    = 32'h98c5;
    arst_n = 1'b0;
    sw     = '0;
    key    = 3'b111;   // Released
    repeat (10) @(posedge CLK_50M);
    #2 arst_n = 1'b1;

    // LED chaser from reset
    start = total_fails();
    @(negedge CLK_50M);
    assert (ledr == 8'h01)
    else
    begin
      $display("ERR ledr exp %h got %h", 8'h01, ledr);
      errors++;
    end
    seen_top  = 1'b0;
    back_home = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      wait_change("ledr", 1, clk_hz + 10, cycles);
      seen_top  = seen_top | ledr[7];
      back_home = back_home | (seen_top & ledr[0]);
    end
    assert (seen_top && back_home)
    else
    begin
      $display("LED pattern did not reach bit 7 and come back to bit 0");
      errors++;
    end
    report_test("leds", start);

    // Tone periods for random switch patterns
    start = total_fails();
    for (int i = 0; i < 10; i++)
    begin
      rnd = xorshift(rnd);
      pattern = (rnd[7:0] == 8'h00) ? 8'h80 : rnd[7:0];
      hp = note_cycles(pattern);
      @(posedge CLK_50M);
      #2 sw = pattern;
      repeat (4) @(negedge CLK_50M);
      wait_change("tone_out", 0, 2 * hp + 10, cycles);
      wait_change("tone_out", 0, 2 * hp + 10, cycles);
      assert (cycles == hp)
      else
      begin
        $display("ERR tone_out half period exp %h got %h", hp, cycles);
        errors++;
      end
    end
    @(posedge CLK_50M);
    #2 sw = 8'h00;
    repeat (4) @(negedge CLK_50M);
    highs = 0;
    repeat (200)
    begin
      @(negedge CLK_50M);
      highs += int'(tone_out);
    end
    assert (highs == 0)
    else
    begin
      $display("ERR tone_out exp %h got %h for %0d cycles", 1'b0, 1'b1, highs);
      errors++;
    end
    report_test("tone", start);

    // Tone runs on for the sample assertions
    start = total_fails();
    @(posedge CLK_50M);
    #2 sw = 8'h10;
    for (int i = 0; i < 6; i++)
    begin
      wait_change("tone_out", 0, 2 * note_cycles(8'h10) + 10, cycles);
    end
    report_test("sample", start);

    // Speed keys
    start = total_fails();
    press_for(0, 3);
    exp_count = count_default + 16'd3 * count_step;
    check_count(exp_count);
    press_for(1, 5);
    exp_count = exp_count - 16'd5 * count_step;
    check_count(exp_count);
    @(posedge CLK_50M);
    #2 key[2] = 1'b0;
    repeat (4) @(posedge CLK_50M);   // Sync, offset, count
    @(negedge CLK_50M);
    check_count(count_default);
    @(posedge CLK_50M);
    #2 key[2] = 1'b1;
    report_test("speed keys", start);

    // Display of a stable count
    start = total_fails();
    press_for(0, 2);
    exp_count = count_default + 16'd2 * count_step;
    check_count(exp_count);
    cycles = 0;
    while (!u_dut.u_ticks.tick_display && cycles <= int'(clk_hz / 2) + 10)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (!u_dut.u_ticks.tick_display)
    begin
      $display("No display tick within %0d cycles", cycles);
      errors++;
    end
    repeat (2) @(negedge CLK_50M);   // Latch, then decode
    check_digit("hex0", hex0, exp_count[3:0]);
    check_digit("hex1", hex1, exp_count[7:4]);
    check_digit("hex2", hex2, exp_count[11:8]);
    check_digit("hex3", hex3, exp_count[15:12]);
    check_digit("hex4", hex4, 4'h0);
    check_digit("hex5", hex5, 4'h0);
    report_test("display", start);

    $display("tests 5, testbench errors %0d, assertion failures %0d",
             errors, u_dut.u_chk.fail_count);
    if (total_fails() == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tick_if.sv */
interface tick_if;

  logic tick_khz;       // 1 kHz
  logic tick_repeat;    // Key repeat rate
  logic tick_led;       // 1 Hz
  logic tick_display;   // 2 Hz

  modport src (
    output tick_khz,
    output tick_repeat,
    output tick_led,
    output tick_display
  );

  modport sink (
    input tick_khz,
    input tick_repeat,
    input tick_led,
    input tick_display
  );

endinterface

/* tone_generator.sv */
module tone_generator #(
  parameter logic [31:0] clk_hz = 32'd50_000_000
) (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [7:0] sw,
  output logic       tone_out,
  output logic [7:0] audio_sample
);
  import organ_pkg::*;

  // Half periods for every note, silent gives 0
  function automatic logic [8:0][31:0] build_hp_tab();
    logic [8:0][31:0] tab;
    for (int i = 0; i < 9; i++)
    begin
      tab[i] = half_period(clk_hz, note_e'(i));
    end
    return tab;
  endfunction

  localparam logic [8:0][31:0] hp_tab = build_hp_tab();

  logic [7:0]  sw_q;
  note_e       note;
  note_e       note_next;
  logic [31:0] cnt;
  logic [31:0] cnt_next;
  logic        tone_next;

  // Lowest set switch wins
  always_comb
  begin
    note_next = silent_n;
    for (int i = 7; i >= 0; i--)
    begin
      if (sw_q[i])
      begin
        note_next = note_e'(i);
      end
    end
  end

  // ==============================
  // Half-period divider
  // ==============================
  always_comb
  begin
    tone_next = tone_out;
    cnt_next  = cnt - 32'd1;
    if (note_next != note)
    begin
      tone_next = 1'b0;                        // Restart on a new note
      cnt_next  = hp_tab[note_next] - 32'd1;
    end
    else if (note == silent_n)
    begin
      tone_next = 1'b0;
      cnt_next  = '0;
    end
    else if (cnt == '0)
    begin
      tone_next = ~tone_out;
      cnt_next  = hp_tab[note] - 32'd1;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sw_q         <= '0;
      note         <= silent_n;
      cnt          <= '0;
      tone_out     <= 1'b0;
      audio_sample <= 8'h80;
    end
    else
    begin
      sw_q         <= sw;
      note         <= note_next;
      cnt          <= cnt_next;
      tone_out     <= tone_next;
      audio_sample <= tone_next ? 8'h7f : 8'h80;   // Signed full swing
    end
  end

endmodule

/* vlog.f */
organ_pkg.sv
tick_if.sv
organ_timebase.sv
tone_generator.sv
key_conditioner.sv
scope_rate_ctrl.sv
led_chaser.sv
seg_display.sv
organ_top.sv
organ_checker.sv
tb_organ.sv
